//--- all.f
src/ahbStagePkg.sv
src/addrDecoder.sv
src/addrHoldStage.sv
src/dataSelectReg.sv
src/defaultSlave.sv
src/respMux.sv
src/masterStage.sv
verification/tbClock.sv
verification/masterStageTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status is the simulation result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module masterStageTb \
	-f all.f \
	-o masterStageSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/masterStageSim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed"
	exit $status
fi

exit 0

//--- src/addrDecoder.sv
// Combinational slot decode; slots at or above NUM_SLOTS or masked off in SLOT_ENABLE are reserved
`timescale 1ns/1ps
module addrDecoder
(
	input  ahbStagePkg::addrT    addr,
	input  ahbStagePkg::htransE  trans,
	output ahbStagePkg::slotSelT sel,
	output logic                 reserved
);

	logic [ahbStagePkg::SLOT_MSB-ahbStagePkg::SLOT_LSB:0] slotNum;
	ahbStagePkg::slotSelT hit;	// Slot field match before the enable mask
	logic active;
	logic outOfRange;

	assign slotNum    = addr[ahbStagePkg::SLOT_MSB:ahbStagePkg::SLOT_LSB];
	assign active     = (trans != ahbStagePkg::IDLE);
	assign outOfRange = (int'(slotNum) >= ahbStagePkg::NUM_SLOTS);

	always_comb
	begin
		for (int i = 0; i < ahbStagePkg::NUM_SLOTS; i++)
			hit[i] = (int'(slotNum) == i);
	end

	// Disabled slots never reach sel
	assign sel = active ? (hit & ahbStagePkg::SLOT_ENABLE) : '0;

	assign reserved = active && (outOfRange || (|(hit & ~ahbStagePkg::SLOT_ENABLE)));

	// Range and mask paths must never claim the same transfer
	always_comb
	begin
		assert final (!(reserved && (|sel)))
		else
			$error("addrDecoder: slot select and reserved both set");
	end

endmodule

//--- src/addrHoldStage.sv
// Address phase hold; master must keep HADDR/HTRANS stable while HREADY is low
`timescale 1ns/1ps
module addrHoldStage
(
	input  logic                 HCLK,
	input  logic                 aresetn,
	input  ahbStagePkg::addrT    HADDR,
	input  logic [2:0]           HSIZE,
	input  ahbStagePkg::htransE  HTRANS,
	input  logic                 HWRITE,
	input  logic                 HREADY,
	input  ahbStagePkg::slotSelT slaveAddrReady,
	output ahbStagePkg::addrT    gatedHaddr,
	output logic [2:0]           gatedHsize,
	output ahbStagePkg::htransE  gatedHtrans,
	output logic                 gatedHwrite,
	output ahbStagePkg::slotSelT addrSel,
	output logic                 addrReserved
);

	ahbStagePkg::holdStateE holdState;
	ahbStagePkg::holdStateE nextState;
	logic                   useReg;	// Drive gated outputs from the hold register
	logic                   capture;

	ahbStagePkg::addrT   regHaddr;
	logic [2:0]          regHsize;
	ahbStagePkg::htransE regHtrans;
	logic                regHwrite;

	always_comb
	begin
		if (useReg)
		begin
			gatedHaddr  = regHaddr;
			gatedHsize  = regHsize;
			gatedHtrans = regHtrans;
			gatedHwrite = regHwrite;
		end
		else
		begin
			gatedHaddr  = HADDR;
			gatedHsize  = HSIZE;
			gatedHtrans = HTRANS;
			gatedHwrite = HWRITE;
		end
	end

	addrDecoder addrDec0
	(
		.addr     (gatedHaddr),
		.trans    (gatedHtrans),
		.sel      (addrSel),
		.reserved (addrReserved)
	);

	always_comb
	begin
		capture   = 1'b0;
		nextState = holdState;
		case (holdState)
		ahbStagePkg::PASS:
		begin
			// Slot busy with another master, keep the address
			if ((HTRANS != ahbStagePkg::IDLE) && HREADY && (|(addrSel & ~slaveAddrReady)))
			begin
				capture   = 1'b1;
				nextState = ahbStagePkg::HELD;
			end
		end
		ahbStagePkg::HELD:
		begin
			if (|(addrSel & slaveAddrReady))
				nextState = ahbStagePkg::PASS;
		end
		default:
			nextState = ahbStagePkg::PASS;
		endcase
	end

	always_ff @(posedge HCLK or negedge aresetn)
	begin
		if (!aresetn)
		begin
			holdState <= ahbStagePkg::PASS;
			useReg    <= 1'b1;	// Register holds IDLE until the first clock
			regHtrans <= ahbStagePkg::IDLE;
		end
		else
		begin
			holdState <= nextState;
			useReg    <= (nextState == ahbStagePkg::HELD);
			if (capture)
				regHtrans <= HTRANS;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (capture)
		begin
			regHaddr  <= HADDR;
			regHsize  <= HSIZE;
			regHwrite <= HWRITE;
		end
	end

	assert property (@(posedge HCLK) disable iff (!aresetn) $onehot0(addrSel))
	else
		$error("addrHoldStage: addrSel not one-hot");

	// Gated outputs follow the master again one edge after the held slot turns address-ready
	assert property (@(posedge HCLK) disable iff (!aresetn)
		((holdState == ahbStagePkg::HELD) && (|(addrSel & slaveAddrReady)))
		|=> ((gatedHaddr == HADDR) && (gatedHtrans == HTRANS)))
	else
		$error("addrHoldStage: hold kept after slot became address-ready");

endmodule

//--- src/ahbStagePkg.sv
// Shared AHB-Lite stage definitions; the slot map assumes four slots chosen by HADDR[31:28]
package ahbStagePkg;

	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int NUM_SLOTS = 4;

	// Slot number field in the address
	localparam int SLOT_MSB = 31;
	localparam int SLOT_LSB = 28;

	typedef logic [ADDR_W-1:0]    addrT;
	typedef logic [DATA_W-1:0]    dataT;
	typedef logic [NUM_SLOTS-1:0] slotSelT;	// One-hot or zero

	// Populated slots, slot 2 left empty
	localparam slotSelT SLOT_ENABLE = 4'b1011;

	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htransE;

	typedef enum logic
	{
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hrespE;

	// Address hold FSM
	typedef enum logic
	{
		PASS = 1'b0,
		HELD = 1'b1
	} holdStateE;

	// Default slave FSM
	typedef enum logic [1:0]
	{
		DS_IDLE = 2'b00,
		DS_ERR1 = 2'b01,
		DS_ERR2 = 2'b10
	} defSlaveStateE;

endpackage

//--- src/dataSelectReg.sv
// Data phase slot select; advances only when the previous data phase completes
`timescale 1ns/1ps
module dataSelectReg
(
	input  logic                 HCLK,
	input  logic                 aresetn,
	input  ahbStagePkg::slotSelT addrSel,
	input  logic                 addrReserved,
	input  logic                 prevReady,
	output ahbStagePkg::slotSelT dataSel,
	output logic                 dataReserved
);

	always_ff @(posedge HCLK or negedge aresetn)
	begin
		if (!aresetn)
		begin
			dataSel      <= '0;
			dataReserved <= 1'b0;
		end
		else if (prevReady)
		begin
			dataSel      <= addrSel;
			dataReserved <= addrReserved;
		end
	end

	assert property (@(posedge HCLK) disable iff (!aresetn) $onehot0(dataSel))
	else
		$error("dataSelectReg: dataSel not one-hot");

endmodule

//--- src/defaultSlave.sv
// Two-cycle ERROR responder; start must stay high until the second cycle completes
`timescale 1ns/1ps
module defaultSlave
(
	input  logic                HCLK,
	input  logic                aresetn,
	input  logic                start,
	output logic                ready,
	output ahbStagePkg::hrespE  resp
);

	ahbStagePkg::defSlaveStateE stateReg;
	ahbStagePkg::defSlaveStateE curState;	// First error cycle is entered without a clock
	ahbStagePkg::defSlaveStateE nextState;

	always_comb
	begin
		curState = stateReg;
		if ((stateReg == ahbStagePkg::DS_IDLE) && start)
			curState = ahbStagePkg::DS_ERR1;
	end

	always_comb
	begin
		case (curState)
		ahbStagePkg::DS_ERR1:
		begin
			ready     = 1'b0;	// Wait state with ERROR
			resp      = ahbStagePkg::ERROR;
			nextState = ahbStagePkg::DS_ERR2;
		end
		ahbStagePkg::DS_ERR2:
		begin
			ready     = 1'b1;
			resp      = ahbStagePkg::ERROR;
			nextState = ahbStagePkg::DS_IDLE;
		end
		default:
		begin
			ready     = 1'b1;
			resp      = ahbStagePkg::OKAY;
			nextState = ahbStagePkg::DS_IDLE;
		end
		endcase
	end

	always_ff @(posedge HCLK or negedge aresetn)
	begin
		if (!aresetn)
			stateReg <= ahbStagePkg::DS_IDLE;
		else
			stateReg <= nextState;
	end

	// Start is held through the wait state so the second ERROR cycle belongs to the same transfer
	assert property (@(posedge HCLK) disable iff (!aresetn)
		(curState == ahbStagePkg::DS_ERR1) |=> (start && (curState == ahbStagePkg::DS_ERR2)))
	else
		$error("defaultSlave: first ERROR cycle not followed by the second");

endmodule

//--- src/masterStage.sv
// AHB-Lite master stage for a single master and four slots; slot arbiters live outside
`timescale 1ns/1ps
module masterStage
(
	input  logic                                           HCLK,
	input  logic                                           aresetn,
	input  ahbStagePkg::addrT                              HADDR,
	input  logic [2:0]                                     HSIZE,
	input  ahbStagePkg::htransE                            HTRANS,
	input  logic                                           HWRITE,
	output logic                                           HREADY,
	output ahbStagePkg::hrespE                             HRESP,
	output ahbStagePkg::dataT                              HRDATA,
	input  ahbStagePkg::slotSelT                           slaveAddrReady,
	input  ahbStagePkg::slotSelT                           slaveReady,
	input  ahbStagePkg::slotSelT                           slaveResp,
	input  ahbStagePkg::dataT [ahbStagePkg::NUM_SLOTS-1:0] slaveRdata,
	output ahbStagePkg::addrT                              gatedHaddr,
	output logic [2:0]                                     gatedHsize,
	output ahbStagePkg::htransE                            gatedHtrans,
	output logic                                           gatedHwrite,
	output ahbStagePkg::slotSelT                           addrSel,
	output ahbStagePkg::slotSelT                           dataSel
);

	logic addrReserved;
	logic dataReserved;
	logic prevReady;	// Previous data phase done, select may advance

	addrHoldStage holdStage0
	(
		.HCLK           (HCLK),
		.aresetn        (aresetn),
		.HADDR          (HADDR),
		.HSIZE          (HSIZE),
		.HTRANS         (HTRANS),
		.HWRITE         (HWRITE),
		.HREADY         (HREADY),
		.slaveAddrReady (slaveAddrReady),
		.gatedHaddr     (gatedHaddr),
		.gatedHsize     (gatedHsize),
		.gatedHtrans    (gatedHtrans),
		.gatedHwrite    (gatedHwrite),
		.addrSel        (addrSel),
		.addrReserved   (addrReserved)
	);

	dataSelectReg selReg0
	(
		.HCLK         (HCLK),
		.aresetn      (aresetn),
		.addrSel      (addrSel),
		.addrReserved (addrReserved),
		.prevReady    (prevReady),
		.dataSel      (dataSel),
		.dataReserved (dataReserved)
	);

	respMux respMux0
	(
		.HCLK         (HCLK),
		.aresetn      (aresetn),
		.dataSel      (dataSel),
		.dataReserved (dataReserved),
		.slaveReady   (slaveReady),
		.slaveResp    (slaveResp),
		.slaveRdata   (slaveRdata),
		.HREADY       (HREADY),
		.HRESP        (HRESP),
		.HRDATA       (HRDATA),
		.prevReady    (prevReady)
	);

endmodule

//--- src/respMux.sv
// Data phase response mux; dataSel is assumed one-hot or zero
`timescale 1ns/1ps
module respMux
(
	input  logic                                                HCLK,
	input  logic                                                aresetn,
	input  ahbStagePkg::slotSelT                                dataSel,
	input  logic                                                dataReserved,
	input  ahbStagePkg::slotSelT                                slaveReady,
	input  ahbStagePkg::slotSelT                                slaveResp,
	input  ahbStagePkg::dataT [ahbStagePkg::NUM_SLOTS-1:0]      slaveRdata,
	output logic                                                HREADY,
	output ahbStagePkg::hrespE                                  HRESP,
	output ahbStagePkg::dataT                                   HRDATA,
	output logic                                                prevReady
);

	logic               readyAfterReset;
	logic               defReady;
	ahbStagePkg::hrespE defResp;

	defaultSlave defSlave0
	(
		.HCLK    (HCLK),
		.aresetn (aresetn),
		.start   (dataReserved),
		.ready   (defReady),
		.resp    (defResp)
	);

	// HREADY stays low until the first clock out of reset
	always_ff @(posedge HCLK or negedge aresetn)
	begin
		if (!aresetn)
			readyAfterReset <= 1'b0;
		else
			readyAfterReset <= 1'b1;
	end

	always_comb
	begin
		HREADY    = readyAfterReset;	// No data phase selected
		HRESP     = ahbStagePkg::OKAY;
		HRDATA    = '0;
		prevReady = 1'b1;
		if (dataReserved)
		begin
			HREADY    = defReady;
			HRESP     = defResp;
			prevReady = defReady;
		end
		else
		begin
			for (int i = 0; i < ahbStagePkg::NUM_SLOTS; i++)
			begin
				if (dataSel[i])
				begin
					HREADY    = slaveReady[i];
					HRESP     = ahbStagePkg::hrespE'(slaveResp[i]);
					HRDATA    = slaveRdata[i];
					prevReady = slaveReady[i];
				end
			end
		end
	end

endmodule

//--- verification/masterStageTb.sv
// Single-master testbench; slot arbiters are modeled only through slaveAddrReady, reads only
`timescale 1ns/1ps
module masterStageTb;

	localparam int NUM_RANDOM = 200;
	localparam int MAX_STALL  = 3;	// Slave model forces ready after this many wait states
	localparam int WATCHDOG_CYCLES = 10 + (NUM_RANDOM + 40) * (MAX_STALL + 2) + 60;

	logic                                           HCLK;
	logic                                           aresetn;
	ahbStagePkg::addrT                              HADDR;
	logic [2:0]                                     HSIZE;
	ahbStagePkg::htransE                            HTRANS;
	logic                                           HWRITE;
	logic                                           HREADY;
	ahbStagePkg::hrespE                             HRESP;
	ahbStagePkg::dataT                              HRDATA;
	ahbStagePkg::slotSelT                           slaveAddrReady;
	ahbStagePkg::slotSelT                           slaveReady;
	ahbStagePkg::slotSelT                           slaveResp;
	ahbStagePkg::dataT [ahbStagePkg::NUM_SLOTS-1:0] slaveRdata;
	ahbStagePkg::addrT                              gatedHaddr;
	logic [2:0]                                     gatedHsize;
	ahbStagePkg::htransE                            gatedHtrans;
	logic                                           gatedHwrite;
	ahbStagePkg::slotSelT                           addrSel;
	ahbStagePkg::slotSelT                           dataSel;

	int unsigned stimState;
	int unsigned readyState;
	int          stallCnt [ahbStagePkg::NUM_SLOTS];
	logic        forceReady;
	logic        monitorOn;
	int          issuedActive;
	int          checkedCount;

	// Data phase tracked by the checker
	logic                 dataValid;
	logic                 dataRes;
	ahbStagePkg::slotSelT dataSelExp;
	ahbStagePkg::dataT    dataWordExp;
	int                   errCycles;	// Cycles spent in a default slave data phase

	tbClock clk0
	(
		.HCLK    (HCLK),
		.aresetn (aresetn)
	);

	masterStage dut0
	(
		.HCLK           (HCLK),
		.aresetn        (aresetn),
		.HADDR          (HADDR),
		.HSIZE          (HSIZE),
		.HTRANS         (HTRANS),
		.HWRITE         (HWRITE),
		.HREADY         (HREADY),
		.HRESP          (HRESP),
		.HRDATA         (HRDATA),
		.slaveAddrReady (slaveAddrReady),
		.slaveReady     (slaveReady),
		.slaveResp      (slaveResp),
		.slaveRdata     (slaveRdata),
		.gatedHaddr     (gatedHaddr),
		.gatedHsize     (gatedHsize),
		.gatedHtrans    (gatedHtrans),
		.gatedHwrite    (gatedHwrite),
		.addrSel        (addrSel),
		.dataSel        (dataSel)
	);

	function automatic int unsigned lcgNext(int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Fixed read word of each slave
	function automatic ahbStagePkg::dataT slotData(int s);
		return {8'h5A, 4'h0, 4'(s), 16'hBEEF};
	endfunction

	// Expected slot for an address, zero means default slave
	function automatic ahbStagePkg::slotSelT refSlot(ahbStagePkg::addrT a);
		int                   slotNum;
		ahbStagePkg::slotSelT sel;
		slotNum = int'(a[ahbStagePkg::SLOT_MSB:ahbStagePkg::SLOT_LSB]);
		sel     = '0;
		if ((slotNum < ahbStagePkg::NUM_SLOTS) && ahbStagePkg::SLOT_ENABLE[slotNum])
			sel[slotNum] = 1'b1;
		return sel;
	endfunction

	task automatic reportMismatch(string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic compareSel(ahbStagePkg::slotSelT act, ahbStagePkg::slotSelT exp, string what);
		if (act !== exp)
			reportMismatch($sformatf("%s is %b, expected %b", what, act, exp));
	endtask

	task automatic compareResp(ahbStagePkg::hrespE act, ahbStagePkg::hrespE exp, string what);
		if (act !== exp)
			reportMismatch($sformatf("%s is %0d, expected %0d", what, act, exp));
	endtask

	task automatic compareData(ahbStagePkg::dataT act, ahbStagePkg::dataT exp, string what);
		if (act !== exp)
			reportMismatch($sformatf("%s is %h, expected %h", what, act, exp));
	endtask

	task automatic compareAddr(ahbStagePkg::addrT act, ahbStagePkg::addrT exp, string what);
		if (act !== exp)
			reportMismatch($sformatf("%s is %h, expected %h", what, act, exp));
	endtask

	task automatic compareTrans(ahbStagePkg::htransE act, ahbStagePkg::htransE exp, string what);
		if (act !== exp)
			reportMismatch($sformatf("%s is %0d, expected %0d", what, act, exp));
	endtask

	task automatic compareSize(logic [2:0] act, logic [2:0] exp, string what);
		if (act !== exp)
			reportMismatch($sformatf("%s is %0d, expected %0d", what, act, exp));
	endtask

	task automatic compareFlag(logic act, logic exp, string what);
		if (act !== exp)
			reportMismatch($sformatf("%s is %b, expected %b", what, act, exp));
	endtask

	// Present one address phase and wait until it is accepted
	task automatic issueXfer(ahbStagePkg::addrT a, ahbStagePkg::htransE t);
		@(negedge HCLK);
		HADDR  = a;
		HTRANS = t;
		HWRITE = 1'b0;
		HSIZE  = 3'b010;
		if (t != ahbStagePkg::IDLE)
			issuedActive++;
		do
			@(posedge HCLK);
		while (!HREADY);
	endtask

	// Slave models, random wait states with a bounded stall
	always @(negedge HCLK)
	begin
		for (int i = 0; i < ahbStagePkg::NUM_SLOTS; i++)
		begin
			readyState = lcgNext(readyState);
			if (forceReady || !aresetn || (stallCnt[i] >= MAX_STALL) || (((readyState >> 20) % 4) != 0))
			begin
				slaveReady[i] = 1'b1;
				stallCnt[i]   = 0;
			end
			else
			begin
				slaveReady[i] = 1'b0;
				stallCnt[i]++;
			end
		end
	end

	// Checker, samples pre-edge values at the rising edge
	always @(posedge HCLK)
	begin : dataPhaseCheck
		ahbStagePkg::slotSelT expAddrSel;
		if (!monitorOn)
			dataValid = 1'b0;
		else
		begin
			expAddrSel = (HTRANS != ahbStagePkg::IDLE) ? refSlot(HADDR) : '0;
			compareSel(addrSel, expAddrSel, "addrSel");
			if (!dataValid)
			begin
				compareFlag(HREADY, 1'b1, "idle HREADY");
				compareResp(HRESP, ahbStagePkg::OKAY, "idle HRESP");
				compareData(HRDATA, '0, "idle HRDATA");
				compareSel(dataSel, '0, "idle dataSel");
			end
			else if (dataRes)
			begin
				errCycles++;
				compareResp(HRESP, ahbStagePkg::ERROR, "default slave HRESP");
				compareData(HRDATA, '0, "default slave HRDATA");
				compareFlag(HREADY, (errCycles == 2), "default slave HREADY");	// Low, then high
				if (HREADY)
					checkedCount++;
			end
			else
			begin
				compareSel(dataSel, dataSelExp, "dataSel");	// Also held during stalls
				compareFlag(HREADY, |(slaveReady & dataSelExp), "slot HREADY");
				if (HREADY)
				begin
					compareResp(HRESP, ahbStagePkg::OKAY, "slot HRESP");
					compareData(HRDATA, dataWordExp, "slot HRDATA");
					checkedCount++;
				end
			end
			if (HREADY)
			begin
				dataValid   = (HTRANS != ahbStagePkg::IDLE);
				dataSelExp  = refSlot(HADDR);
				dataRes     = (refSlot(HADDR) == '0);
				dataWordExp = slotData(int'(HADDR[ahbStagePkg::SLOT_MSB:ahbStagePkg::SLOT_LSB]));
				errCycles   = 0;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * 40);
		$display("Timeout: the transfers did not complete within the expected time");
		$display("Some tests failed");
		$fatal(1, "Watchdog expired");
	end

	initial
	begin
		ahbStagePkg::addrT   heldAddr;
		ahbStagePkg::addrT   otherAddr;
		ahbStagePkg::addrT   addr;
		ahbStagePkg::htransE trans;
		int unsigned         pick;
		int unsigned         slotNum;
		HADDR          = '0;
		HSIZE          = 3'b010;
		HTRANS         = ahbStagePkg::IDLE;
		HWRITE         = 1'b0;
		slaveAddrReady = '1;
		slaveReady     = '1;
		slaveResp      = '0;
		for (int i = 0; i < ahbStagePkg::NUM_SLOTS; i++)
		begin
			slaveRdata[i] = slotData(i);
			stallCnt[i]   = 0;
		end
		stimState    = 77;
		readyState   = 77;
		forceReady   = 1'b0;
		monitorOn    = 1'b0;
		issuedActive = 0;
		checkedCount = 0;
		dataValid    = 1'b0;
		dataRes      = 1'b0;
		dataSelExp   = '0;
		dataWordExp  = '0;
		errCycles    = 0;

		@(posedge HCLK);
		compareFlag(HREADY, 1'b0, "HREADY in reset");
		compareTrans(gatedHtrans, ahbStagePkg::IDLE, "gatedHtrans in reset");
		wait (aresetn);
		@(posedge HCLK);
		@(negedge HCLK);
		monitorOn = 1'b1;

		// Directed reads, enabled slots then reserved ones
		issueXfer(32'h0000_0100, ahbStagePkg::NONSEQ);
		issueXfer(32'h1000_0204, ahbStagePkg::NONSEQ);
		issueXfer(32'h3000_0008, ahbStagePkg::NONSEQ);
		issueXfer(32'h2000_0000, ahbStagePkg::NONSEQ);
		issueXfer(32'h4000_0010, ahbStagePkg::NONSEQ);
		issueXfer(32'hF000_0000, ahbStagePkg::NONSEQ);
		issueXfer(32'h0000_0040, ahbStagePkg::NONSEQ);
		issueXfer(32'h0000_0000, ahbStagePkg::IDLE);

		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			stimState = lcgNext(stimState);
			pick      = (stimState >> 16) % 6;
			slotNum   = (pick == 4) ? 4 + ((stimState >> 8) % 12) : pick % 4;
			addr      = {4'(slotNum), stimState[29:4], 2'b00};
			if (pick == 5)
				trans = ahbStagePkg::IDLE;
			else
				trans = stimState[3] ? ahbStagePkg::SEQ : ahbStagePkg::NONSEQ;
			issueXfer(addr, trans);
		end

		// Address hold with slot 1 not address-ready
		repeat (2) issueXfer(32'h0000_0000, ahbStagePkg::IDLE);
		@(posedge HCLK);
		monitorOn  = 1'b0;
		forceReady = 1'b1;
		heldAddr   = 32'h1000_0080;
		otherAddr  = 32'h3000_0400;
		@(negedge HCLK);
		slaveAddrReady = 4'b1101;
		HADDR          = heldAddr;
		HTRANS         = ahbStagePkg::NONSEQ;
		HSIZE          = 3'b010;
		HWRITE         = 1'b0;
		@(posedge HCLK);
		compareAddr(gatedHaddr, heldAddr, "gatedHaddr before capture");
		@(negedge HCLK);
		HADDR  = otherAddr;	// Master moves on
		HTRANS = ahbStagePkg::SEQ;
		HSIZE  = 3'b001;
		HWRITE = 1'b1;
		repeat (3)
		begin
			@(posedge HCLK);
			compareAddr(gatedHaddr, heldAddr, "held gatedHaddr");
			compareTrans(gatedHtrans, ahbStagePkg::NONSEQ, "held gatedHtrans");
			compareSize(gatedHsize, 3'b010, "held gatedHsize");
			compareFlag(gatedHwrite, 1'b0, "held gatedHwrite");
		end
		@(negedge HCLK);
		slaveAddrReady = '1;
		@(posedge HCLK);
		compareAddr(gatedHaddr, heldAddr, "gatedHaddr in release cycle");
		@(posedge HCLK);
		compareAddr(gatedHaddr, otherAddr, "gatedHaddr after release");
		compareTrans(gatedHtrans, ahbStagePkg::SEQ, "gatedHtrans after release");
		compareSize(gatedHsize, 3'b001, "gatedHsize after release");
		compareFlag(gatedHwrite, 1'b1, "gatedHwrite after release");
		@(negedge HCLK);
		HADDR  = '0;
		HTRANS = ahbStagePkg::IDLE;
		HSIZE  = 3'b010;
		HWRITE = 1'b0;
		repeat (3) @(posedge HCLK);
		forceReady = 1'b0;
		@(negedge HCLK);
		monitorOn = 1'b1;

		repeat (3) issueXfer(32'h0000_0000, ahbStagePkg::IDLE);
		@(negedge HCLK);
		if (checkedCount == issuedActive)
		begin
			$display("All tests passed");
			$finish;
		end
		else
		begin
			$display("Only %0d of %0d checked transfers completed", checkedCount, issuedActive);
			$display("Some tests failed");
			$fatal(1, "Transfer count wrong");
		end
	end

endmodule

//--- verification/tbClock.sv
// Testbench clock and reset; HCLK period is 40 ns and aresetn is released on a falling edge
`timescale 1ns/1ps
module tbClock
(
	output logic HCLK,
	output logic aresetn
);

	initial
	begin
		HCLK = 1'b0;
		forever
			#20 HCLK = ~HCLK;
	end

	initial
	begin
		aresetn = 1'b0;
		repeat (5) @(posedge HCLK);
		@(negedge HCLK);
		aresetn = 1'b1;	// Away from the rising edge
	end

endmodule
